// ==== common/bpred_pkg.sv ====
package bpred_pkg;

  // ----------------------------------------------------------
  // Widths and sizes
  // ----------------------------------------------------------
  localparam int unsigned XLEN        = 32;
  localparam int unsigned INSTR_BYTES = 4;
  localparam int unsigned BTB_ENTRIES = 16;
  // Index is PC[5:2], tag is PC[31:6]
  localparam int unsigned BTB_IDX_W   = 4;
  localparam int unsigned BTB_TAG_W   = 26;
  localparam int unsigned RAS_DEPTH   = 8;
  localparam int unsigned RAS_PTR_W   = 3;

  // Vector types with a meaning
  typedef logic [XLEN-1:0]      xaddr_t;
  typedef logic [BTB_IDX_W-1:0] btb_idx_t;
  typedef logic [BTB_TAG_W-1:0] btb_tag_t;
  typedef logic [RAS_PTR_W-1:0] ras_ptr_t;

  // Which rule produced the next fetch PC
  typedef enum logic [2:0] {
    SRC_SEQ      = 3'd0,
    SRC_BTB      = 3'd1,
    SRC_RAS      = 3'd2,
    SRC_REDIRECT = 3'd3,
    SRC_HOLD     = 3'd4
  } pred_src_t;

  // ----------------------------------------------------------
  // Bundles between execute, fetch and the predictors
  // ----------------------------------------------------------
  typedef struct packed {
    logic   valid;
    xaddr_t target;
  } redirect_t;

  typedef struct packed {
    logic   en;
    xaddr_t pc;
    xaddr_t target;
    logic   taken;
    logic   is_return;
  } btb_update_t;

  typedef struct packed {
    logic   hit;
    logic   taken;
    logic   is_return;
    xaddr_t target;
  } btb_lookup_t;

  typedef struct packed {
    logic   en;
    xaddr_t addr;
  } ras_push_t;

  typedef struct packed {
    logic   valid;
    xaddr_t target;
  } ras_top_t;

endpackage

// ==== btb/branch_target_buffer.sv ====
`timescale 1ns/1ps

module branch_target_buffer (
  input  logic                   clk,
  input  logic                   rst_n,
  // Fetch PC to look up
  input  bpred_pkg::xaddr_t      lookup_pc,
  // Training from execute
  input  bpred_pkg::btb_update_t update,
  // Prediction for lookup_pc
  output bpred_pkg::btb_lookup_t lookup
);

  import bpred_pkg::*;

  // ----------------------------------------------------------
  // Storage, one slot per index
  // ----------------------------------------------------------
  logic [BTB_ENTRIES-1:0] valid_q;
  btb_tag_t               tag_q       [BTB_ENTRIES];
  xaddr_t                 target_q    [BTB_ENTRIES];
  logic [BTB_ENTRIES-1:0] taken_q;
  logic [BTB_ENTRIES-1:0] is_return_q;

  // Address split for lookup and update
  btb_idx_t lk_idx;
  btb_tag_t lk_tag;
  btb_idx_t upd_idx;
  btb_tag_t upd_tag;
  logic     lk_hit;

  // Word-aligned PC, index right above the byte offset
  assign lk_idx  = lookup_pc[BTB_IDX_W+1:2];
  assign lk_tag  = lookup_pc[XLEN-1:BTB_IDX_W+2];
  assign upd_idx = update.pc[BTB_IDX_W+1:2];
  assign upd_tag = update.pc[XLEN-1:BTB_IDX_W+2];

  // ----------------------------------------------------------
  // Combinational read
  // ----------------------------------------------------------
  assign lk_hit = valid_q[lk_idx] && (tag_q[lk_idx] == lk_tag);

  always_comb begin
    lookup.hit = lk_hit;
    // Fields read as zero on a miss
    lookup.taken     = lk_hit && taken_q[lk_idx];
    lookup.is_return = lk_hit && is_return_q[lk_idx];
    lookup.target    = lk_hit ? target_q[lk_idx] : '0;
  end

  // ----------------------------------------------------------
  // Registered update
  // ----------------------------------------------------------

  // Valid bits cleared on reset, set on any write
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (update.en) begin
      valid_q[upd_idx] <= 1'b1;
    end
  end

  // Entry payload
  // A not-taken update still overwrites the entry
  always_ff @(posedge clk) begin
    if (update.en) begin
      tag_q[upd_idx]       <= upd_tag;
      target_q[upd_idx]    <= update.target;
      taken_q[upd_idx]     <= update.taken;
      is_return_q[upd_idx] <= update.is_return;
    end
  end

endmodule

// ==== ras/return_address_stack.sv ====
`timescale 1ns/1ps

module return_address_stack (
  input  logic                 clk,
  input  logic                 rst_n,
  // Call return address from execute
  input  bpred_pkg::ras_push_t push,
  // Predicted return consumes the top
  input  logic                 pop,
  output bpred_pkg::ras_top_t  top
);

  import bpred_pkg::*;

  // Circular storage, top_ptr points at the newest entry
  xaddr_t             stack_q [RAS_DEPTH];
  ras_ptr_t           top_ptr_q;
  // One bit wider than the pointer, saturates at RAS_DEPTH
  logic [RAS_PTR_W:0] count_q;

  logic               not_empty;
  logic               full;
  logic               pop_ok;
  ras_ptr_t           wr_ptr;

  assign not_empty = (count_q != '0);
  assign full      = (count_q == (RAS_PTR_W+1)'(RAS_DEPTH));
  // Pop on empty is ignored
  assign pop_ok    = pop && not_empty;

  // Push and pop together replace the top in place
  assign wr_ptr = pop_ok ? top_ptr_q : top_ptr_q + 1'b1;

  // ----------------------------------------------------------
  // Pointer and occupancy
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      top_ptr_q <= '0;
      count_q   <= '0;
    end else if (push.en && !pop_ok) begin
      // Wrapping pointer drops the oldest entry when full
      top_ptr_q <= top_ptr_q + 1'b1;
      if (!full) begin
        count_q <= count_q + 1'b1;
      end
    end else if (pop_ok && !push.en) begin
      top_ptr_q <= top_ptr_q - 1'b1;
      count_q   <= count_q - 1'b1;
    end
  end

  // Return address storage
  always_ff @(posedge clk) begin
    if (push.en) begin
      stack_q[wr_ptr] <= push.addr;
    end
  end

  assign top.valid  = not_empty;
  assign top.target = stack_q[top_ptr_q];

endmodule

// ==== design/next_pc_arbiter.sv ====
`timescale 1ns/1ps

module next_pc_arbiter (
  input  bpred_pkg::xaddr_t      fetch_pc,
  input  logic                   fetch_en,
  input  bpred_pkg::redirect_t   redirect,
  input  bpred_pkg::btb_lookup_t lookup,
  input  bpred_pkg::ras_top_t    top,
  output bpred_pkg::xaddr_t      next_pc,
  output bpred_pkg::pred_src_t   pred_src,
  // Pulse back to the stack on a predicted return
  output logic                   ras_pop
);

  import bpred_pkg::*;

  xaddr_t seq_pc;
  logic   ret_hit;
  logic   taken_hit;

  // Fall-through address
  assign seq_pc = fetch_pc + XLEN'(INSTR_BYTES);

  // Return only predicted when the stack has something
  assign ret_hit   = lookup.hit && lookup.is_return && top.valid;
  assign taken_hit = lookup.hit && lookup.taken;

  // ----------------------------------------------------------
  // Priority select
  // ----------------------------------------------------------
  always_comb begin
    ras_pop = 1'b0;
    if (redirect.valid) begin
      // Execute correction beats everything
      next_pc  = redirect.target;
      pred_src = SRC_REDIRECT;
    end else if (!fetch_en) begin
      // Stall holds the PC and keeps the stack intact
      next_pc  = fetch_pc;
      pred_src = SRC_HOLD;
    end else if (ret_hit) begin
      next_pc  = top.target;
      pred_src = SRC_RAS;
      ras_pop  = 1'b1;
    end else if (taken_hit) begin
      next_pc  = lookup.target;
      pred_src = SRC_BTB;
    end else begin
      next_pc  = seq_pc;
      pred_src = SRC_SEQ;
    end
  end

endmodule

// ==== design/bpred_frontend.sv ====
`timescale 1ns/1ps

module bpred_frontend (
  input  logic                   clk,
  input  logic                   rst_n,
  // Fetch side
  input  bpred_pkg::xaddr_t      fetch_pc,
  input  logic                   fetch_en,
  // Execute side strobes
  input  bpred_pkg::redirect_t   redirect,
  input  bpred_pkg::btb_update_t btb_update,
  input  bpred_pkg::ras_push_t   ras_push,
  // Prediction result
  output bpred_pkg::xaddr_t      next_pc,
  output bpred_pkg::pred_src_t   pred_src
);

  import bpred_pkg::*;

  // BTB result for the current fetch PC
  btb_lookup_t lookup;
  // Current top of the return stack
  ras_top_t    top;
  // Pop pulse when a return is predicted
  logic        ras_pop;

  // ----------------------------------------------------------
  // Predictors, looked up in parallel
  // ----------------------------------------------------------
  branch_target_buffer u_btb (
    .clk      (clk),
    .rst_n    (rst_n),
    .lookup_pc(fetch_pc),
    .update   (btb_update),
    .lookup   (lookup)
  );

  return_address_stack u_ras (
    .clk  (clk),
    .rst_n(rst_n),
    .push (ras_push),
    .pop  (ras_pop),
    .top  (top)
  );

  // Final next-PC choice
  next_pc_arbiter u_arb (
    .fetch_pc(fetch_pc),
    .fetch_en(fetch_en),
    .redirect(redirect),
    .lookup  (lookup),
    .top     (top),
    .next_pc (next_pc),
    .pred_src(pred_src),
    .ras_pop (ras_pop)
  );

endmodule

// ==== bench/bpred_vectors.svh ====
`ifndef BPRED_VECTORS_SVH
`define BPRED_VECTORS_SVH

// Columns: fetch_pc, fetch_en, redirect, btb_update, ras_push, exp next_pc, exp pred_src
// Updates and pushes take effect from the following row
task automatic load_table();
  // Empty predictors after reset
  add_row('{32'h0000_0100, 1'b1, '0, '0, '0, 32'h0000_0104, SRC_SEQ});
  add_row('{32'h0000_0100, 1'b0, '0, '0, '0, 32'h0000_0100, SRC_HOLD});
  // Train a taken branch at 0x200 while stalled
  add_row('{32'h0000_0200, 1'b0, '0, train(32'h0000_0200, 32'h0000_0340, 1'b1, 1'b0), '0,
            32'h0000_0200, SRC_HOLD});
  add_row('{32'h0000_0200, 1'b1, '0, '0, '0, 32'h0000_0340, SRC_BTB});
  // Same index, other tag misses; train a not-taken entry at 0x208
  add_row('{32'h0000_0300, 1'b1, '0, train(32'h0000_0208, 32'h0000_0500, 1'b0, 1'b0), '0,
            32'h0000_0304, SRC_SEQ});
  add_row('{32'h0000_0208, 1'b1, '0, '0, '0, 32'h0000_020c, SRC_SEQ});
  // Return at 0x404 with fallback target, calls push A then B
  add_row('{32'h0000_0400, 1'b1, '0, train(32'h0000_0404, 32'h0000_0600, 1'b1, 1'b1),
            call_push(32'h0000_1000), 32'h0000_0404, SRC_SEQ});
  add_row('{32'h0000_0410, 1'b1, '0, '0, call_push(32'h0000_2000), 32'h0000_0414, SRC_SEQ});
  add_row('{32'h0000_0404, 1'b1, '0, '0, '0, 32'h0000_2000, SRC_RAS});
  add_row('{32'h0000_0404, 1'b1, '0, '0, '0, 32'h0000_1000, SRC_RAS});
  add_row('{32'h0000_0404, 1'b1, '0, '0, '0, 32'h0000_0600, SRC_BTB});
  // Nine pushes during a stall, the first one is lost
  add_row('{32'h0000_0404, 1'b0, '0, '0, call_push(32'h0000_3010), 32'h0000_0404, SRC_HOLD});
  add_row('{32'h0000_0404, 1'b0, '0, '0, call_push(32'h0000_3020), 32'h0000_0404, SRC_HOLD});
  add_row('{32'h0000_0404, 1'b0, '0, '0, call_push(32'h0000_3030), 32'h0000_0404, SRC_HOLD});
  add_row('{32'h0000_0404, 1'b0, '0, '0, call_push(32'h0000_3040), 32'h0000_0404, SRC_HOLD});
  add_row('{32'h0000_0404, 1'b0, '0, '0, call_push(32'h0000_3050), 32'h0000_0404, SRC_HOLD});
  add_row('{32'h0000_0404, 1'b0, '0, '0, call_push(32'h0000_3060), 32'h0000_0404, SRC_HOLD});
  add_row('{32'h0000_0404, 1'b0, '0, '0, call_push(32'h0000_3070), 32'h0000_0404, SRC_HOLD});
  add_row('{32'h0000_0404, 1'b0, '0, '0, call_push(32'h0000_3080), 32'h0000_0404, SRC_HOLD});
  add_row('{32'h0000_0404, 1'b0, '0, '0, call_push(32'h0000_3090), 32'h0000_0404, SRC_HOLD});
  // Eight returns newest first, then the BTB target
  add_row('{32'h0000_0404, 1'b1, '0, '0, '0, 32'h0000_3090, SRC_RAS});
  add_row('{32'h0000_0404, 1'b1, '0, '0, '0, 32'h0000_3080, SRC_RAS});
  add_row('{32'h0000_0404, 1'b1, '0, '0, '0, 32'h0000_3070, SRC_RAS});
  add_row('{32'h0000_0404, 1'b1, '0, '0, '0, 32'h0000_3060, SRC_RAS});
  add_row('{32'h0000_0404, 1'b1, '0, '0, '0, 32'h0000_3050, SRC_RAS});
  add_row('{32'h0000_0404, 1'b1, '0, '0, '0, 32'h0000_3040, SRC_RAS});
  add_row('{32'h0000_0404, 1'b1, '0, '0, '0, 32'h0000_3030, SRC_RAS});
  add_row('{32'h0000_0404, 1'b1, '0, '0, '0, 32'h0000_3020, SRC_RAS});
  add_row('{32'h0000_0404, 1'b1, '0, '0, '0, 32'h0000_0600, SRC_BTB});
  // Redirect over a BTB hit and over a stall
  add_row('{32'h0000_0200, 1'b1, redir(32'h0000_7000), '0, '0, 32'h0000_7000, SRC_REDIRECT});
  add_row('{32'h0000_0200, 1'b0, redir(32'h0000_7100), '0, '0, 32'h0000_7100, SRC_REDIRECT});
  // Stalled or redirected return keeps the stack top
  add_row('{32'h0000_0410, 1'b1, '0, '0, call_push(32'h0000_8000), 32'h0000_0414, SRC_SEQ});
  add_row('{32'h0000_0404, 1'b0, '0, '0, '0, 32'h0000_0404, SRC_HOLD});
  add_row('{32'h0000_0404, 1'b1, redir(32'h0000_7200), '0, '0, 32'h0000_7200, SRC_REDIRECT});
  add_row('{32'h0000_0404, 1'b1, '0, '0, '0, 32'h0000_8000, SRC_RAS});
  add_row('{32'h0000_0404, 1'b1, '0, '0, '0, 32'h0000_0600, SRC_BTB});
endtask

`endif

// ==== bench/tb_bpred_frontend.sv ====
`timescale 1ns/1ps

module tb_bpred_frontend;

  import bpred_pkg::*;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 3;
  // Extra cycles allowed beyond the table length
  localparam int SLACK_CYCLES = 20;

  // One table row holding stimulus and expected result
  typedef struct packed {
    xaddr_t      fetch_pc;
    logic        fetch_en;
    redirect_t   redirect;
    btb_update_t btb_update;
    ras_push_t   ras_push;
    xaddr_t      exp_pc;
    pred_src_t   exp_src;
  } vec_t;

  logic        clk;
  logic        rst_n;
  xaddr_t      fetch_pc;
  logic        fetch_en;
  redirect_t   redirect;
  btb_update_t btb_update;
  ras_push_t   ras_push;
  xaddr_t      next_pc;
  pred_src_t   pred_src;

  vec_t rows [$];
  int   errors;
  int   checks;
  int   cycles;
  int   cycle_limit;

  bpred_frontend u_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .fetch_pc  (fetch_pc),
    .fetch_en  (fetch_en),
    .redirect  (redirect),
    .btb_update(btb_update),
    .ras_push  (ras_push),
    .next_pc   (next_pc),
    .pred_src  (pred_src)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  // ----------------------------------------------------------
  // Row builders used by the vector table
  // ----------------------------------------------------------
  function automatic redirect_t redir(input xaddr_t target);
    redirect_t r;
    r.valid  = 1'b1;
    r.target = target;
    return r;
  endfunction

  function automatic btb_update_t train(input xaddr_t pc, input xaddr_t target,
                                        input logic taken, input logic is_return);
    btb_update_t u;
    u.en        = 1'b1;
    u.pc        = pc;
    u.target    = target;
    u.taken     = taken;
    u.is_return = is_return;
    return u;
  endfunction

  function automatic ras_push_t call_push(input xaddr_t addr);
    ras_push_t p;
    p.en   = 1'b1;
    p.addr = addr;
    return p;
  endfunction

  task automatic add_row(input vec_t r);
    rows.push_back(r);
  endtask

  `include "bpred_vectors.svh"

  // Compare one value and report a mismatch
  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR %s expected 0x%08h actual 0x%08h", name, exp, act);
    end
  endtask

  // ----------------------------------------------------------
  // Watchdog with its limit set once the table is loaded
  // ----------------------------------------------------------
  initial begin : watchdog
    cycles = 0;
    wait (cycle_limit > 0);
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, the table was not finished", cycles);
    $display("Summary: %0d checks, %0d errors", checks, errors);
    $display("CHECKS FAILED");
    $finish;
  end

  // ----------------------------------------------------------
  // Reset followed by one row per cycle
  // ----------------------------------------------------------
  initial begin : main
    int idx;
    errors      = 0;
    checks      = 0;
    cycle_limit = 0;
    rst_n       = 1'b0;
    fetch_pc    = '0;
    fetch_en    = 1'b0;
    redirect    = '0;
    btb_update  = '0;
    ras_push    = '0;
    load_table();
    cycle_limit = rows.size() + RESET_CYCLES + SLACK_CYCLES;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (idx = 0; idx < rows.size(); idx++) begin
      // Inputs change on the falling edge
      fetch_pc   = rows[idx].fetch_pc;
      fetch_en   = rows[idx].fetch_en;
      redirect   = rows[idx].redirect;
      btb_update = rows[idx].btb_update;
      ras_push   = rows[idx].ras_push;
      // Sample 1 ns before the rising edge
      #(CLK_PERIOD/2 - 1);
      check_value($sformatf("next_pc row %0d", idx), rows[idx].exp_pc, next_pc);
      check_value($sformatf("pred_src row %0d", idx), 32'(rows[idx].exp_src),
                  32'(pred_src));
      @(negedge clk);
    end
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+bench
common/bpred_pkg.sv
btb/branch_target_buffer.sv
ras/return_address_stack.sv
design/next_pc_arbiter.sv
design/bpred_frontend.sv
bench/tb_bpred_frontend.sv

// ==== Makefile ====
# Verilator simulation of the next-PC prediction front end

VERILATOR ?= verilator
TOP       ?= tb_bpred_frontend
FLAGS     ?= --assert
BUILD_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FLAGS BUILD_DIR"

test:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f tb.f \
		-Mdir $(BUILD_DIR) -o V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf $(BUILD_DIR)
